/* filelist.f */
+incdir+source
source/pdp8_pkg.sv
source/front_panel.sv
source/state_machine.sv
source/pc.sv
source/ma.sv
source/ac.sv
source/oper2.sv
source/pdp8e.sv
sim/pdp8e_checker.sv
sim/pdp8e_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the PDP-8/E testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module pdp8e_tb \
    -Mdir obj_dir -o pdp8e_sim
./obj_dir/pdp8e_sim > sim.log 2>&1
cat sim.log

if grep -q "TEST FAIL" sim.log; then
    exit 1
fi
exit 0

/* sim/pdp8e_checker.sv */
// checker that compares the DUT outputs with the expected values on a strobe
`timescale 1ns/1ns

module pdp8e_checker
    import pdp8_pkg::*;
(
    input  logic       clk,
    input  logic       strobe,
    input  logic [3:0] sel,    // ac, link, pc, mb from the top bit down.
    input  int         row,
    input  word_t      exp_ac,
    input  logic       exp_link,
    input  word_t      exp_pc,
    input  word_t      exp_mb,
    input  word_t      ac,
    input  logic       link,
    input  word_t      pc,
    input  word_t      mb,
    output int         checks,
    output int         errors
);

    int n_checks = 0;
    int n_errors = 0;

    assign checks = n_checks;
    assign errors = n_errors;

    task automatic compare_word(input string name, input word_t got, input word_t want);
        n_checks++;
        if (got !== want)
        begin
            n_errors++;
            $display("Error %0t ns: row %0d %s is %04o, expected %04o",
                     $time, row, name, got, want);
        end
    endtask

    // the DUT is halted and quiet while the strobe is high.
    always @(posedge clk)
    begin
        if (strobe)
        begin
            if (sel[3])
                compare_word("ac", ac, exp_ac);
            if (sel[2])
                compare_word("link", word_t'(link), word_t'(exp_link));
            if (sel[1])
                compare_word("pc", pc, exp_pc);
            if (sel[0])
                compare_word("mb", mb, exp_mb);
        end
    end

endmodule

/* sim/pdp8e_tb.sv */
// testbench top with clock, reset, program table, panel stimulus loop, timeout and report
`timescale 1ns/1ns

module pdp8e_tb
    import pdp8_pkg::*;
();

    localparam int NUM_ROWS       = 7;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 400;

    localparam logic [2:0] SW_LOAD = 3'b100;
    localparam logic [2:0] SW_DEP  = 3'b010;
    localparam logic [2:0] SW_EXAM = 3'b001;

    localparam logic [3:0] CHK_AC   = 4'b1000;
    localparam logic [3:0] CHK_LINK = 4'b0100;
    localparam logic [3:0] CHK_PC   = 4'b0010;
    localparam logic [3:0] CHK_MB   = 4'b0001;

    typedef struct packed {
        word_t       start;
        logic [3:0]  nwords;
        word_t [0:7] prog;
        word_t       daddr;
        word_t       dword;
        word_t       run_sr;
        word_t       exp_ac;
        logic        exp_link;
        word_t       exp_pc;
        word_t       exp_mem;
    } row_t;

    logic       clk;
    logic       rst_n;
    word_t      sr;
    logic       load_addr_sw;
    logic       dep_sw;
    logic       exam_sw;
    logic       cont_sw;
    logic       halt_sw;
    logic       run;
    word_t      pc;
    word_t      ac;
    word_t      mb;
    logic       link;
    logic       strobe;
    logic [3:0] check_sel;
    word_t      exp_ac;
    logic       exp_link;
    word_t      exp_pc;
    word_t      exp_mb;
    int         row_idx;
    int         checks;
    int         errors;
    int         cycle_count;
    logic       in_run;
    row_t       rows [NUM_ROWS];

    pdp8e DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .sr           (sr),
        .load_addr_sw (load_addr_sw),
        .dep_sw       (dep_sw),
        .exam_sw      (exam_sw),
        .cont_sw      (cont_sw),
        .halt_sw      (halt_sw),
        .run          (run),
        .pc           (pc),
        .ac           (ac),
        .mb           (mb),
        .link         (link)
    );

    pdp8e_checker u_checker (
        .clk      (clk),
        .strobe   (strobe),
        .sel      (check_sel),
        .row      (row_idx),
        .exp_ac   (exp_ac),
        .exp_link (exp_link),
        .exp_pc   (exp_pc),
        .exp_mb   (exp_mb),
        .ac       (ac),
        .link     (link),
        .pc       (pc),
        .mb       (mb),
        .checks   (checks),
        .errors   (errors)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // every row starts with its own clear of ac and link, since they persist between runs.
    task automatic fill_table();
        word_t tad_a;
        word_t tad_b;
        int    tad_total;
        tad_a     = word_t'($urandom());
        tad_b     = word_t'($urandom());
        tad_total = int'(tad_a) + int'(tad_b);
        rows[0] = '{start: 12'o0100, nwords: 4'd6,
                    prog: '{12'o7300, 12'o7402, 12'o1234, 12'o4321,
                            12'o7777, 12'o0001, 12'o0000, 12'o0000},
                    daddr: 12'o0020, dword: 12'o5555, run_sr: 12'o0000,
                    exp_ac: 12'o0000, exp_link: 1'b0, exp_pc: 12'o0102, exp_mem: 12'o5555};
        rows[1] = '{start: 12'o0200, nwords: 4'd7,
                    prog: '{12'o7300, 12'o1205, 12'o1206, 12'o3207,
                            12'o7402, tad_a, tad_b, 12'o0000},
                    daddr: 12'o0207, dword: 12'o7777, run_sr: 12'o0000,
                    exp_ac: 12'o0000, exp_link: tad_total > 4095, exp_pc: 12'o0205,
                    exp_mem: word_t'(tad_total % 4096)};
        // the indirect TAD goes through the pointer at 0047.
        rows[2] = '{start: 12'o0040, nwords: 4'd8,
                    prog: '{12'o7300, 12'o1045, 12'o0046, 12'o1447,
                            12'o7402, 12'o6543, 12'o0707, 12'o0300},
                    daddr: 12'o0300, dword: 12'o0123, run_sr: 12'o0000,
                    exp_ac: 12'o0626, exp_link: 1'b0, exp_pc: 12'o0045, exp_mem: 12'o0123};
        rows[3] = '{start: 12'o0600, nwords: 4'd3,
                    prog: '{12'o7341, 12'o3210, 12'o7402, 12'o0000,
                            12'o0000, 12'o0000, 12'o0000, 12'o0000},
                    daddr: 12'o0610, dword: 12'o2525, run_sr: 12'o0000,
                    exp_ac: 12'o0000, exp_link: 1'b1, exp_pc: 12'o0603, exp_mem: 12'o0000};
        rows[4] = '{start: 12'o1000, nwords: 4'd8,
                    prog: '{12'o7300, 12'o1207, 12'o7004, 12'o3210,
                            12'o1207, 12'o7012, 12'o7402, 12'o4321},
                    daddr: 12'o1010, dword: 12'o7777, run_sr: 12'o0000,
                    exp_ac: 12'o7064, exp_link: 1'b0, exp_pc: 12'o1007, exp_mem: 12'o0642};
        // the count word at 1410 starts at minus three.
        rows[5] = '{start: 12'o1400, nwords: 4'd8,
                    prog: '{12'o7300, 12'o2210, 12'o5201, 12'o4205,
                            12'o7402, 12'o0000, 12'o7001, 12'o5605},
                    daddr: 12'o1410, dword: 12'o7775, run_sr: 12'o0000,
                    exp_ac: 12'o0001, exp_link: 1'b0, exp_pc: 12'o1405, exp_mem: 12'o0000};
        rows[6] = '{start: 12'o2000, nwords: 4'd8,
                    prog: '{12'o7300, 12'o7450, 12'o7001, 12'o3220,
                            12'o7430, 12'o7402, 12'o7604, 12'o7402},
                    daddr: 12'o2020, dword: 12'o7777, run_sr: 12'o5252,
                    exp_ac: 12'o5252, exp_link: 1'b0, exp_pc: 12'o2010, exp_mem: 12'o0001};
    endtask

    task automatic press_switch(input logic [2:0] sw, input word_t value);
        @(posedge clk);
        sr                                <= value;
        {load_addr_sw, dep_sw, exam_sw} <= sw;
        repeat (4) @(posedge clk);
        {load_addr_sw, dep_sw, exam_sw} <= 3'b000;
        repeat (3) @(posedge clk);
    endtask

    task automatic check_outputs(input logic [3:0] sel, input word_t e_ac, input logic e_link,
                                 input word_t e_pc, input word_t e_mb);
        @(posedge clk);
        strobe    <= 1'b1;
        check_sel <= sel;
        exp_ac    <= e_ac;
        exp_link  <= e_link;
        exp_pc    <= e_pc;
        exp_mb    <= e_mb;
        @(posedge clk);
        strobe <= 1'b0;
    endtask

    // cont stays pressed until run is seen, because a short program can halt within a press.
    task automatic run_program(input row_t row);
        press_switch(SW_LOAD, row.start);
        @(posedge clk);
        sr      <= row.run_sr;
        cont_sw <= 1'b1;
        do
            @(posedge clk);
        while (run !== 1'b1);
        cont_sw <= 1'b0;
        in_run = 1'b1;
        do
            @(posedge clk);
        while (run !== 1'b0);
        in_run = 1'b0;
        repeat (4) @(posedge clk);
    endtask

    task automatic run_row(input row_t row);
        press_switch(SW_LOAD, row.start);
        for (int i = 0; i < int'(row.nwords); i++)
            press_switch(SW_DEP, row.prog[i]);
        check_outputs(CHK_PC, '0, 1'b0, row.start + word_t'(row.nwords), '0);
        press_switch(SW_LOAD, row.start);
        for (int i = 0; i < int'(row.nwords); i++)
        begin
            press_switch(SW_EXAM, row.start);
            check_outputs(CHK_PC | CHK_MB, '0, 1'b0, row.start + word_t'(i + 1), row.prog[i]);
        end
        press_switch(SW_LOAD, row.daddr);
        press_switch(SW_DEP, row.dword);
        run_program(row);
        check_outputs(CHK_AC | CHK_LINK | CHK_PC, row.exp_ac, row.exp_link, row.exp_pc, '0);
        press_switch(SW_LOAD, row.daddr);
        press_switch(SW_EXAM, row.daddr);
        check_outputs(CHK_PC | CHK_MB, '0, 1'b0, row.daddr + 12'd1, row.exp_mem);
    endtask

    initial
    begin
        rst_n        <= 1'b0;
        sr           <= '0;
        load_addr_sw <= 1'b0;
        dep_sw       <= 1'b0;
        exam_sw      <= 1'b0;
        cont_sw      <= 1'b0;
        halt_sw      <= 1'b0;
        strobe       <= 1'b0;
        check_sel    <= '0;
        exp_ac       <= '0;
        exp_link     <= 1'b0;
        exp_pc       <= '0;
        exp_mb       <= '0;
        in_run = 1'b0;
        row_idx = 0;
        void'($urandom(83));
        fill_table();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        for (int r = 0; r < NUM_ROWS; r++)
        begin
            row_idx = r;
            run_row(rows[r]);
        end
        repeat (2) @(posedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

    initial
    begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycle_count++;
        end
        if (in_run)
            $display("the program of row %0d did not halt before the cycle limit", row_idx);
        else
            $display("the testbench stalled in row %0d and reached the cycle limit", row_idx);
        $display("checks %0d, errors %0d", checks, errors);
        $display("TEST FAIL");
        $finish;
    end

endmodule

/* source/ac.sv */
// accumulator and link with AND, TAD, DCA, group-1 operate and OSR
`timescale 1ns/1ns
`include "pdp8_defines.svh"

module ac
    import pdp8_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  major_state_t state,
    input  word_t        instruction,
    input  word_t        mb,
    input  word_t        sr,
    output word_t        ac,
    output logic         link
);

    logic [12:0] tad_sum;
    logic [12:0] lac;
    word_t       ac_next;
    logic        link_next;

    assign tad_sum = {1'b0, ac} + {1'b0, mb};

    always_comb
    begin
        lac       = {link, ac};
        ac_next   = ac;
        link_next = link;
        if (state == EXECUTE)
        begin
            case (opcode_of(instruction))
                OP_AND:
                    ac_next = ac & mb;
                OP_TAD:
                begin
                    ac_next   = tad_sum[11:0];
                    link_next = link ^ tad_sum[12]; // carry complements the link.
                end
                OP_DCA:
                    ac_next = '0;
                OP_OPR:
                begin
                    if (!instruction[`PDP8_GRP_BIT])
                    begin
                        if (instruction[`PDP8_CLA_BIT])
                            lac[11:0] = '0;
                        if (instruction[5])
                            lac[12] = 1'b0; // CLL.
                        if (instruction[6])
                            lac[11:0] = ~lac[11:0];
                        if (instruction[7])
                            lac[12] = ~lac[12];
                        if (instruction[11])
                            lac = lac + 13'd1; // IAC counts through the link.
                        // bit 10 turns a single rotate into a double one.
                        if (instruction[8])
                            lac = instruction[10] ? {lac[1:0], lac[12:2]} : {lac[0], lac[12:1]};
                        if (instruction[9])
                            lac = instruction[10] ? {lac[10:0], lac[12:11]}
                                                  : {lac[11:0], lac[12]};
                        {link_next, ac_next} = lac;
                    end
                    else
                    begin
                        if (instruction[`PDP8_CLA_BIT])
                            ac_next = '0;
                        if (instruction[9])
                            ac_next = ac_next | sr; // OSR after CLA.
                    end
                end
                default:
                    ac_next = ac;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            ac   <= '0;
            link <= 1'b0;
        end
        else
        begin
            ac   <= ac_next;
            link <= link_next;
        end
    end

endmodule

/* source/front_panel.sv */
// front panel switch synchroniser and one-cycle command pulse generator
`timescale 1ns/1ns

module front_panel
    import pdp8_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         load_addr_sw,
    input  logic         dep_sw,
    input  logic         exam_sw,
    input  logic         cont_sw,
    input  major_state_t state,
    output logic         load_addr_p,
    output logic         dep_p,
    output logic         exam_p,
    output logic         cont_p
);

    logic [3:0] sw_level;
    logic [3:0] sync_a;
    logic [3:0] sync_b;
    logic [3:0] sw_last;
    logic [3:0] pulse;

    assign sw_level = {load_addr_sw, dep_sw, exam_sw, cont_sw};

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            sync_a  <= '0;
            sync_b  <= '0;
            sw_last <= '0;
            pulse   <= '0;
        end
        else
        begin
            sync_a  <= sw_level;
            sync_b  <= sync_a;
            sw_last <= sync_b;
            // a switch press is ignored while a program is running.
            pulse   <= (state == HALTED) ? (sync_b & ~sw_last) : 4'b0000;
        end
    end

    assign {load_addr_p, dep_p, exam_p, cont_p} = pulse;

    assert property (@(posedge clk) disable iff (!rst_n) $onehot0(pulse));
    assert property (@(posedge clk) disable iff (!rst_n) (pulse != '0) |-> state == HALTED);

endmodule

/* source/ma.sv */
// memory address, instruction register, 4K core, memory buffer and ISZ logic
`timescale 1ns/1ns
`include "pdp8_defines.svh"

module ma
    import pdp8_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  major_state_t state,
    input  word_t        pc,
    input  word_t        ac,
    input  word_t        sr,
    input  logic         dep_p,
    input  logic         exam_p,
    output word_t        instruction,
    output word_t        ma,
    output word_t        mb,
    output logic         isz_skip
);

    localparam word_t offset_mask = word_t'(`PDP8_PAGE_WORDS - 1);

    word_t core [0:`PDP8_MEM_WORDS-1];
    word_t ir;
    word_t eff_addr;
    word_t isz_sum;
    logic  mem_we;
    word_t mem_wa;
    word_t mem_wd;

    assign instruction = (state == FETCH) ? core[pc] : ir;

    // page zero, or the page that holds the instruction itself.
    assign eff_addr = (instruction & offset_mask)
                      | (instruction[`PDP8_PAGE_BIT] ? (pc & ~offset_mask) : '0);

    assign isz_sum  = mb + 12'd1;
    assign isz_skip = state == EXECUTE && opcode_of(ir) == OP_ISZ && isz_sum == '0;

    always_comb
    begin
        mem_we = 1'b0;
        mem_wa = ma;
        mem_wd = isz_sum;
        if (state == HALTED && dep_p)
        begin
            mem_we = 1'b1;
            mem_wa = pc;
            mem_wd = sr;
        end
        else if (state == EXECUTE)
        begin
            case (opcode_of(ir))
                OP_ISZ:
                    mem_we = 1'b1;
                OP_DCA:
                begin
                    mem_we = 1'b1;
                    mem_wd = ac;
                end
                OP_JMS:
                begin
                    mem_we = 1'b1;
                    mem_wd = pc; // pc already points past the JMS.
                end
                default:
                    mem_we = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (mem_we)
            core[mem_wa] <= mem_wd;
    end

    // mb always holds the word at ma when EXECUTE begins.
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            ir <= '0;
            ma <= '0;
            mb <= '0;
        end
        else if (state == FETCH)
        begin
            ir <= instruction;
            ma <= eff_addr;
            mb <= core[eff_addr];
        end
        else if (state == DEFER)
        begin
            ma <= mb;
            mb <= core[mb];
        end
        else
        begin
            if (dep_p || exam_p)
                ma <= pc;
            if (mem_we)
                mb <= mem_wd;
            else if (exam_p)
                mb <= core[pc];
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) !(mem_we && exam_p));

endmodule

/* source/oper2.sv */
// group-2 operate skip condition decode
`timescale 1ns/1ns
`include "pdp8_defines.svh"

module oper2
    import pdp8_pkg::*;
(
    input  word_t        instruction,
    input  word_t        ac,
    input  logic         link,
    input  major_state_t state,
    output logic         skip
);

    logic grp2_exec;
    logic cond;

    assign grp2_exec = state == EXECUTE && opcode_of(instruction) == OP_OPR
                       && instruction[`PDP8_GRP_BIT];

    // ac is tested before any CLA of the same word takes effect.
    assign cond = (instruction[5] && ac[0])       // SMA
                  || (instruction[6] && ac == '0) // SZA
                  || (instruction[7] && link);    // SNL

    // with no condition selected the reverse sense gives an unconditional skip.
    assign skip = grp2_exec && (cond ^ instruction[8]);

endmodule

/* source/pc.sv */
// program counter with fetch increment, skips, jumps and panel loads
`timescale 1ns/1ns

module pc
    import pdp8_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  major_state_t state,
    input  word_t        instruction,
    input  word_t        ma,
    input  word_t        sr,
    input  logic         skip,
    input  logic         isz_skip,
    input  logic         load_addr_p,
    input  logic         dep_p,
    input  logic         exam_p,
    output word_t        pc
);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            pc <= '0;
        else if (load_addr_p)
            pc <= sr;
        else if (dep_p || exam_p)
            pc <= pc + 12'd1; // the panel steps through memory.
        else if (state == FETCH)
            pc <= pc + 12'd1;
        else if (state == EXECUTE)
        begin
            case (opcode_of(instruction))
                OP_JMP:
                    pc <= ma;
                OP_JMS:
                    pc <= ma + 12'd1; // the return address sits at ma.
                default:
                    if (skip || isz_skip)
                        pc <= pc + 12'd1;
            endcase
        end
    end

endmodule

/* source/pdp8_defines.svh */
// memory size, page size and instruction bit positions
`ifndef PDP8_DEFINES_SVH
`define PDP8_DEFINES_SVH

`define PDP8_MEM_WORDS  4096
`define PDP8_PAGE_WORDS 128
`define PDP8_IND_BIT    3
`define PDP8_PAGE_BIT   4
`define PDP8_GRP_BIT    3
`define PDP8_CLA_BIT    4
`define PDP8_HLT_BIT    10
`endif

/* source/pdp8_pkg.sv */
// PDP-8 word, major-state and opcode types with small instruction decode helpers
package pdp8_pkg;

    typedef logic [0:11] word_t; // bit 0 is the most significant bit.

    typedef enum logic [1:0]
    {
        FETCH,
        DEFER,
        EXECUTE,
        HALTED
    } major_state_t;

    typedef enum logic [2:0]
    {
        OP_AND,
        OP_TAD,
        OP_ISZ,
        OP_DCA,
        OP_JMS,
        OP_JMP,
        OP_IOT,
        OP_OPR
    } opcode_t;

    function automatic opcode_t opcode_of(word_t w);
        return opcode_t'(w[0:2]);
    endfunction

    // AND through JMP address memory, IOT and OPR do not.
    function automatic logic is_mem_ref(word_t w);
        return opcode_of(w) != OP_IOT && opcode_of(w) != OP_OPR;
    endfunction

endpackage

/* source/pdp8e.sv */
// PDP-8/E processor top level with front panel, sequencer and datapath blocks
`timescale 1ns/1ns

module pdp8e
    import pdp8_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  word_t sr,
    input  logic  load_addr_sw,
    input  logic  dep_sw,
    input  logic  exam_sw,
    input  logic  cont_sw,
    input  logic  halt_sw,
    output logic  run,
    output word_t pc,
    output word_t ac,
    output word_t mb,
    output logic  link
);

    major_state_t state;
    word_t        instruction;
    word_t        ma;
    logic         skip;
    logic         isz_skip;
    logic         load_addr_p;
    logic         dep_p;
    logic         exam_p;
    logic         cont_p;

    front_panel u_front_panel (
        .clk          (clk),
        .rst_n        (rst_n),
        .load_addr_sw (load_addr_sw),
        .dep_sw       (dep_sw),
        .exam_sw      (exam_sw),
        .cont_sw      (cont_sw),
        .state        (state),
        .load_addr_p  (load_addr_p),
        .dep_p        (dep_p),
        .exam_p       (exam_p),
        .cont_p       (cont_p)
    );

    state_machine u_state_machine (
        .clk         (clk),
        .rst_n       (rst_n),
        .instruction (instruction),
        .cont_p      (cont_p),
        .halt_sw     (halt_sw),
        .state       (state),
        .run         (run)
    );

    pc u_pc (
        .clk         (clk),
        .rst_n       (rst_n),
        .state       (state),
        .instruction (instruction),
        .ma          (ma),
        .sr          (sr),
        .skip        (skip),
        .isz_skip    (isz_skip),
        .load_addr_p (load_addr_p),
        .dep_p       (dep_p),
        .exam_p      (exam_p),
        .pc          (pc)
    );

    ma u_ma (
        .clk         (clk),
        .rst_n       (rst_n),
        .state       (state),
        .pc          (pc),
        .ac          (ac),
        .sr          (sr),
        .dep_p       (dep_p),
        .exam_p      (exam_p),
        .instruction (instruction),
        .ma          (ma),
        .mb          (mb),
        .isz_skip    (isz_skip)
    );

    ac u_ac (
        .clk         (clk),
        .rst_n       (rst_n),
        .state       (state),
        .instruction (instruction),
        .mb          (mb),
        .sr          (sr),
        .ac          (ac),
        .link        (link)
    );

    oper2 u_oper2 (
        .instruction (instruction),
        .ac          (ac),
        .link        (link),
        .state       (state),
        .skip        (skip)
    );

endmodule

/* source/state_machine.sv */
// major-state sequencer for fetch, defer, execute and halt, with the run flag
`timescale 1ns/1ns
`include "pdp8_defines.svh"

module state_machine
    import pdp8_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  word_t        instruction,
    input  logic         cont_p,
    input  logic         halt_sw,
    output major_state_t state,
    output logic         run
);

    major_state_t next_state;
    logic         defer_needed;
    logic         hlt_op;

    // during FETCH the instruction input already shows the word being fetched.
    assign defer_needed = is_mem_ref(instruction) && instruction[`PDP8_IND_BIT];
    assign hlt_op = opcode_of(instruction) == OP_OPR && instruction[`PDP8_GRP_BIT]
                    && instruction[`PDP8_HLT_BIT];

    always_comb
    begin
        next_state = state;
        case (state)
            HALTED:
                if (cont_p)
                    next_state = FETCH;
            FETCH:
                next_state = defer_needed ? DEFER : EXECUTE;
            DEFER:
                next_state = EXECUTE;
            EXECUTE:
                next_state = (hlt_op || halt_sw) ? HALTED : FETCH; // the instruction completes first.
            default:
                next_state = HALTED;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state <= HALTED;
            run   <= 1'b0;
        end
        else
        begin
            state <= next_state;
            run   <= next_state != HALTED;
        end
    end

    // in DEFER the instruction input comes from the latched instruction register.
    assert property (@(posedge clk) disable iff (!rst_n)
        state == DEFER |-> $past(state == FETCH) && defer_needed);

endmodule
